//--- fetch_unit.f
+incdir+logic
logic/fetch_pkg.sv
logic/btac.sv
logic/itim.sv
logic/itim_arbiter.sv
logic/itim_loader.sv
logic/fetch_stage.sv
logic/fetch_unit.sv
test/tb_clock.sv
test/fetch_checker.sv
test/fetch_unit_tb.sv

//--- logic/btac.sv
`include "fetch_cfg.svh"

module btac (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::addr_t      lookup_pc,
  output fetch_pkg::btac_pred_t pred,
  input  fetch_pkg::btac_upd_t  btac_upd
);
  import fetch_pkg::*;

  logic [`BTAC_ENTRIES-1:0] valid_q;
  btac_tag_t                tag_q [`BTAC_ENTRIES];
  addr_t                    target_q [`BTAC_ENTRIES];
  btac_index_t              lookup_index;
  btac_tag_t                lookup_tag;
  btac_index_t              upd_index;
  btac_tag_t                upd_tag;

  // Bits 2:0 address bytes inside a bundle, so the index starts at bit 3
  assign lookup_index = lookup_pc[`BTAC_INDEX_WIDTH+2:3];
  assign lookup_tag   = lookup_pc[`FETCH_ADDR_WIDTH-1:`BTAC_INDEX_WIDTH+3];
  assign upd_index    = btac_upd.pc[`BTAC_INDEX_WIDTH+2:3];
  assign upd_tag      = btac_upd.pc[`FETCH_ADDR_WIDTH-1:`BTAC_INDEX_WIDTH+3];

  always_comb begin
    pred.hit    = valid_q[lookup_index] & (tag_q[lookup_index] == lookup_tag);
    pred.target = target_q[lookup_index];
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_q <= '0;
    end else if (btac_upd.valid) begin
      valid_q[upd_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (btac_upd.valid) begin
      tag_q[upd_index]    <= upd_tag;
      target_q[upd_index] <= btac_upd.target; // A newer branch evicts the old one
    end
  end

endmodule

//--- logic/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Byte address width of the fetch path
`define FETCH_ADDR_WIDTH 32

// Instruction memory size in 64-bit words and the matching index width
`define ITIM_DEPTH 1024
`define ITIM_INDEX_WIDTH 10

// Branch target cache size and the matching index width
`define BTAC_ENTRIES 16
`define BTAC_INDEX_WIDTH 4

`endif

//--- logic/fetch_pkg.sv
`include "fetch_cfg.svh"

package fetch_pkg;

  typedef logic [`FETCH_ADDR_WIDTH-1:0] addr_t;
  typedef logic [63:0] bundle_t;
  typedef logic [7:0] strobe_t;
  typedef logic [`ITIM_INDEX_WIDTH-1:0] itim_index_t;
  typedef logic [`BTAC_INDEX_WIDTH-1:0] btac_index_t;
  typedef logic [`FETCH_ADDR_WIDTH-`BTAC_INDEX_WIDTH-4:0] btac_tag_t;

  localparam logic [1:0] axi_okay = 2'b00;

  typedef struct packed {
    logic    valid;
    logic    write;
    addr_t   addr;
    bundle_t wdata;
    strobe_t wstrb;
  } itim_req_t;

  typedef struct packed {
    logic    ready;
    bundle_t rdata;
  } itim_rsp_t;

  typedef struct packed {
    logic  trap;
    logic  mret;
    logic  miss;
    logic  fence;
    addr_t mtvec;
    addr_t mepc;
    addr_t miss_addr;
    addr_t fence_npc;
  } redirect_t;

  typedef struct packed {
    logic  valid;
    addr_t pc;
    addr_t target;
  } btac_upd_t;

  typedef struct packed {
    logic  hit;
    addr_t target;
  } btac_pred_t;

  typedef struct packed {
    logic    valid;
    addr_t   pc;
    bundle_t rdata;
    logic    taken;
  } fetch_out_t;

  typedef struct packed {
    addr_t addr;
  } axil_aw_t;

  typedef struct packed {
    bundle_t data;
    strobe_t strb;
  } axil_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  // Idle has nothing in flight, busy awaits a live bundle, ctrl awaits a cancelled one
  typedef enum logic [1:0] {
    idle,
    busy,
    ctrl
  } fetch_state_t;

endpackage

//--- logic/fetch_stage.sv
module fetch_stage (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::redirect_t  redirect,
  input  logic                  halt,
  input  fetch_pkg::btac_pred_t pred,
  output fetch_pkg::addr_t      lookup_pc,
  output fetch_pkg::itim_req_t  fetch_req,
  input  logic                  fetch_grant,
  input  fetch_pkg::itim_rsp_t  fetch_rsp,
  output fetch_pkg::fetch_out_t fetch_out
);
  import fetch_pkg::*;

  fetch_state_t state_q;
  fetch_state_t state_d;
  addr_t        pc_q;
  addr_t        pc_d;
  addr_t        out_pc_q;
  logic         out_taken_q;
  logic         redirect_any;
  logic         accepted;
  logic         arrive;

  assign redirect_any = redirect.trap | redirect.mret | redirect.miss | redirect.fence;
  assign accepted     = fetch_req.valid & fetch_grant;
  assign arrive       = (state_q == busy) & fetch_rsp.ready; // Bundle for a live request

  assign lookup_pc = pc_q; // BTAC is probed with the address going out now

  always_comb begin
    fetch_req       = '0;
    fetch_req.valid = !halt; // No new request while the back end is stalled
    fetch_req.write = 1'b0;
    fetch_req.addr  = pc_q;
  end

  // Next fetch address, highest priority first
  always_comb begin
    pc_d = pc_q;
    if (redirect.trap) begin
      pc_d = redirect.mtvec;
    end else if (redirect.mret) begin
      pc_d = redirect.mepc;
    end else if (redirect.miss) begin
      pc_d = redirect.miss_addr;
    end else if (redirect.fence) begin
      pc_d = redirect.fence_npc;
    end else if (arrive && halt) begin
      pc_d = out_pc_q; // Rewind so the dropped bundle is fetched again
    end else if (accepted) begin
      pc_d = pred.hit ? pred.target : pc_q + addr_t'(8);
    end
  end

  always_comb begin
    if (accepted) begin
      // A request issued alongside a redirect is on the wrong path
      state_d = redirect_any ? ctrl : busy;
    end else begin
      state_d = idle;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= idle;
      pc_q    <= '0;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

  // Tag of the request in flight, paired with the data as it returns
  always_ff @(posedge clock) begin
    if (accepted) begin
      out_pc_q    <= pc_q;
      out_taken_q <= pred.hit;
    end
  end

  always_comb begin
    fetch_out.valid = arrive & !halt;
    fetch_out.pc    = out_pc_q;
    fetch_out.rdata = fetch_rsp.rdata;
    fetch_out.taken = out_taken_q;
  end

endmodule

//--- logic/fetch_unit.sv
module fetch_unit (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::redirect_t  redirect,
  input  logic                  halt,
  input  fetch_pkg::btac_upd_t  btac_upd,
  input  fetch_pkg::axil_aw_t   aw,
  input  logic                  awvalid,
  output logic                  awready,
  input  fetch_pkg::axil_w_t    w,
  input  logic                  wvalid,
  output logic                  wready,
  output fetch_pkg::axil_b_t    b,
  output logic                  bvalid,
  input  logic                  bready,
  output fetch_pkg::fetch_out_t fetch_out
);
  import fetch_pkg::*;

  addr_t      lookup_pc;
  btac_pred_t pred;
  itim_req_t  fetch_req;
  itim_req_t  load_req;
  itim_req_t  mem_req;
  itim_rsp_t  mem_rsp;
  itim_rsp_t  fetch_rsp;
  logic       fetch_grant;
  logic       load_grant;

  fetch_stage fetch_stage_i (
    .clock, .reset, .redirect, .halt, .pred, .lookup_pc,
    .fetch_req, .fetch_grant, .fetch_rsp, .fetch_out
  );

  btac btac_i (.clock, .reset, .lookup_pc, .pred, .btac_upd);

  itim_loader itim_loader_i (
    .clock, .reset, .aw, .awvalid, .awready, .w, .wvalid, .wready,
    .b, .bvalid, .bready, .load_req, .load_grant
  );

  itim_arbiter itim_arbiter_i (
    .clock, .reset, .fetch_req, .load_req, .fetch_grant, .load_grant,
    .mem_req, .mem_rsp, .fetch_rsp
  );

  itim itim_i (.clock, .req(mem_req), .rsp(mem_rsp));

endmodule

//--- logic/itim.sv
`include "fetch_cfg.svh"

module itim (
  input  logic                 clock,
  input  fetch_pkg::itim_req_t req,
  output fetch_pkg::itim_rsp_t rsp
);
  import fetch_pkg::*;

  bundle_t     mem [`ITIM_DEPTH];
  itim_index_t index;
  logic        ready_q;
  bundle_t     rdata_q;

  assign index = req.addr[`ITIM_INDEX_WIDTH+2:3];

  always_ff @(posedge clock) begin
    if (req.valid && req.write) begin
      for (int i = 0; i < 8; i++) begin
        if (req.wstrb[i]) begin
          mem[index][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    ready_q <= req.valid & !req.write; // Writes get no response
    if (req.valid && !req.write) begin
      rdata_q <= mem[index];
    end
  end

  always_comb begin
    rsp.ready = ready_q;
    rsp.rdata = rdata_q;
  end

  // Both requesters must stay on whole words inside the array
  a_addr_in_range: assert property (@(posedge clock)
    req.valid |-> (req.addr[2:0] == 3'b000) && (req.addr < addr_t'(`ITIM_DEPTH * 8)))
    else $error("itim request address %h misaligned or out of range", req.addr);

endmodule

//--- logic/itim_arbiter.sv
module itim_arbiter (
  input  logic                 clock,
  input  logic                 reset,
  input  fetch_pkg::itim_req_t fetch_req,
  input  fetch_pkg::itim_req_t load_req,
  output logic                 fetch_grant,
  output logic                 load_grant,
  output fetch_pkg::itim_req_t mem_req,
  input  fetch_pkg::itim_rsp_t mem_rsp,
  output fetch_pkg::itim_rsp_t fetch_rsp
);

  logic fetch_owner_q;

  assign load_grant  = load_req.valid; // Loader always wins
  assign fetch_grant = !load_req.valid;
  assign mem_req     = load_grant ? load_req : fetch_req;

  always_ff @(posedge clock) begin
    if (!reset) begin
      fetch_owner_q <= 1'b0;
    end else begin
      fetch_owner_q <= fetch_grant & fetch_req.valid & !fetch_req.write;
    end
  end

  always_comb begin
    fetch_rsp.ready = mem_rsp.ready & fetch_owner_q;
    fetch_rsp.rdata = mem_rsp.rdata;
  end

  // Memory must answer only the read it accepted one cycle earlier
  a_rsp_follows_read: assert property (@(posedge clock) disable iff (!reset)
    mem_rsp.ready |-> $past(mem_req.valid && !mem_req.write))
    else $error("itim response without a preceding read");

endmodule

//--- logic/itim_loader.sv
module itim_loader (
  input  logic                 clock,
  input  logic                 reset,
  input  fetch_pkg::axil_aw_t  aw,
  input  logic                 awvalid,
  output logic                 awready,
  input  fetch_pkg::axil_w_t   w,
  input  logic                 wvalid,
  output logic                 wready,
  output fetch_pkg::axil_b_t   b,
  output logic                 bvalid,
  input  logic                 bready,
  output fetch_pkg::itim_req_t load_req,
  input  logic                 load_grant
);
  import fetch_pkg::*;

  logic    aw_held_q;
  logic    w_held_q;
  logic    bvalid_q;
  addr_t   addr_q;
  bundle_t data_q;
  strobe_t strb_q;
  logic    issue;

  // Both channels stay closed until the pending response is taken
  assign awready = !aw_held_q & !bvalid_q;
  assign wready  = !w_held_q & !bvalid_q;
  assign issue   = load_req.valid & load_grant;
  assign bvalid  = bvalid_q;
  assign b.resp  = axi_okay;

  always_comb begin
    load_req.valid = aw_held_q & w_held_q;
    load_req.write = 1'b1;
    load_req.addr  = addr_q;
    load_req.wdata = data_q;
    load_req.wstrb = strb_q;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
      bvalid_q  <= 1'b0;
    end else begin
      if (awvalid && awready) begin
        aw_held_q <= 1'b1;
      end else if (issue) begin
        aw_held_q <= 1'b0;
      end
      if (wvalid && wready) begin
        w_held_q <= 1'b1;
      end else if (issue) begin
        w_held_q <= 1'b0;
      end
      if (issue) begin
        bvalid_q <= 1'b1; // Write lands in the itim on this edge
      end else if (bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (awvalid && awready) begin
      addr_q <= aw.addr;
    end
    if (wvalid && wready) begin
      data_q <= w.data;
      strb_q <= w.strb;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
  --top-module fetch_unit_tb -f fetch_unit.f -o fetch_unit_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/fetch_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
exit 0

//--- test/fetch_checker.sv
`include "fetch_cfg.svh"

module fetch_checker (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::redirect_t  redirect,
  input  logic                  halt,
  input  fetch_pkg::btac_upd_t  btac_upd,
  input  fetch_pkg::axil_aw_t   aw,
  input  logic                  awvalid,
  input  logic                  awready,
  input  fetch_pkg::axil_w_t    w,
  input  logic                  wvalid,
  input  logic                  wready,
  input  fetch_pkg::axil_b_t    b,
  input  logic                  bvalid,
  input  logic                  bready,
  input  fetch_pkg::fetch_out_t fetch_out,
  output int                    errors,
  output int                    checks,
  output int                    aw_count,
  output int                    b_count
);
  import fetch_pkg::*;

  bundle_t mem_model [`ITIM_DEPTH];
  strobe_t known [`ITIM_DEPTH]; // Bytes written so far, the rest is undefined
  logic    btac_valid [`BTAC_ENTRIES];
  addr_t   btac_pc [`BTAC_ENTRIES];
  addr_t   btac_target [`BTAC_ENTRIES];
  addr_t   expected_pc;
  logic    pred_hit;
  addr_t   pred_target;
  addr_t   pend_addr;
  bundle_t pend_data;
  strobe_t pend_strb;
  logic    in_reset;
  logic    b_pending;

  function automatic bundle_t byte_mask(input strobe_t strb);
    bundle_t mask;
    for (int i = 0; i < 8; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    return mask;
  endfunction

  task automatic compare(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  initial begin
    errors   = 0;
    checks   = 0;
    aw_count = 0;
    b_count  = 0;
    in_reset = 1'b0;
    for (int i = 0; i < `ITIM_DEPTH; i++) begin
      known[i] = '0;
    end
  end

  always @(posedge clock) begin : watch
    int      idx;
    int      bi;
    bundle_t mask;
    if (!reset) begin
      if (in_reset) begin
        compare("reset_fetch_valid", 64'd0, 64'(fetch_out.valid));
        compare("reset_bvalid", 64'd0, 64'(bvalid));
      end
      in_reset    = 1'b1;
      expected_pc = '0; // First bundle comes from address zero
      pred_hit    = 1'b0;
      b_pending   = 1'b0;
      for (int i = 0; i < `BTAC_ENTRIES; i++) begin
        btac_valid[i] = 1'b0;
      end
    end else begin
      if (halt && fetch_out.valid) begin
        errors++;
        $display("A valid bundle appeared while halt was high");
      end
      if (fetch_out.valid) begin
        compare("fetch_pc", 64'(expected_pc), 64'(fetch_out.pc));
        idx = int'(fetch_out.pc >> 3);
        if (idx < `ITIM_DEPTH) begin
          mask = byte_mask(known[idx]);
          compare("fetch_rdata", mem_model[idx] & mask, fetch_out.rdata & mask);
        end
        compare("fetch_taken", 64'(pred_hit), 64'(fetch_out.taken));
        expected_pc = pred_hit ? pred_target : expected_pc + 32'd8;
      end
      if (redirect.trap) begin
        expected_pc = redirect.mtvec;
      end else if (redirect.mret) begin
        expected_pc = redirect.mepc;
      end else if (redirect.miss) begin
        expected_pc = redirect.miss_addr;
      end else if (redirect.fence) begin
        expected_pc = redirect.fence_npc;
      end
      // Prediction seen by the request that goes out this cycle
      bi          = int'(expected_pc >> 3) % `BTAC_ENTRIES;
      pred_hit    = btac_valid[bi] && (btac_pc[bi] == expected_pc);
      pred_target = btac_target[bi];
      if (btac_upd.valid) begin
        bi              = int'(btac_upd.pc >> 3) % `BTAC_ENTRIES;
        btac_valid[bi]  = 1'b1;
        btac_pc[bi]     = btac_upd.pc;
        btac_target[bi] = btac_upd.target;
      end
      if (awvalid && awready) begin
        pend_addr = aw.addr;
        aw_count++;
      end
      if (wvalid && wready) begin
        pend_data = w.data;
        pend_strb = w.strb;
      end
      if (bvalid && !b_pending) begin
        b_count++;
        compare("axi_bresp", 64'd0, 64'(b.resp)); // OKAY is encoded as zero
        if (b_count > aw_count) begin
          errors++;
          $display("Write response arrived with no write outstanding");
        end
        idx = int'(pend_addr >> 3);
        for (int i = 0; i < 8; i++) begin
          if (pend_strb[i] && idx < `ITIM_DEPTH) begin
            mem_model[idx][8*i +: 8] = pend_data[8*i +: 8];
            known[idx][i]            = 1'b1;
          end
        end
      end
      b_pending = bvalid && !bready; // Same response still waiting next cycle
    end
  end

endmodule

//--- test/fetch_unit_tb.sv
module fetch_unit_tb;
  import fetch_pkg::*;

  localparam int load_writes  = 48;
  localparam int load_cycles  = load_writes * 4;
  localparam int mix_cycles   = 600;
  localparam int mix_writes   = 24;
  localparam int drain_cycles = 20;
  localparam int cycle_limit  = 2 * (load_cycles + mix_cycles + drain_cycles);

  logic       clock;
  logic       reset;
  redirect_t  redirect;
  logic       halt;
  btac_upd_t  btac_upd;
  axil_aw_t   aw;
  logic       awvalid;
  logic       awready;
  axil_w_t    w;
  logic       wvalid;
  logic       wready;
  axil_b_t    b;
  logic       bvalid;
  logic       bready;
  fetch_out_t fetch_out;
  int         errors;
  int         checks;
  int         aw_count;
  int         b_count;
  int         tb_errors = 0;
  int         cycles = 0;

  tb_clock clock_gen_i (.clock, .reset);

  fetch_unit dut_i (.*);

  fetch_checker checker_i (.*);

  // Keeps fetch inside the low part of the itim
  function automatic addr_t random_word_addr();
    return addr_t'($urandom_range(0, 63)) << 3;
  endfunction

  task automatic axi_write(input addr_t addr, input bundle_t data, input strobe_t strb);
    int   aw_wait;
    int   w_wait;
    logic aw_done;
    logic w_done;
    aw_wait = $urandom_range(0, 2); // Channels may open in either order
    w_wait  = $urandom_range(0, 2);
    aw_done = 1'b0;
    w_done  = 1'b0;
    aw.addr = addr;
    w.data  = data;
    w.strb  = strb;
    while (!(aw_done && w_done)) begin
      @(negedge clock);
      awvalid = !aw_done && (aw_wait == 0);
      wvalid  = !w_done && (w_wait == 0);
      if (aw_wait > 0) aw_wait--;
      if (w_wait > 0) w_wait--;
      @(posedge clock);
      if (awvalid && awready) aw_done = 1'b1;
      if (wvalid && wready) w_done = 1'b1;
    end
    @(negedge clock);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge clock);
  endtask

  task automatic drive_mix_cycle();
    @(negedge clock);
    halt     = ($urandom_range(0, 5) == 0);
    bready   = ($urandom_range(0, 3) != 0);
    redirect = '0;
    if ($urandom_range(0, 7) == 0) begin
      redirect.trap  = ($urandom_range(0, 3) == 0);
      redirect.mret  = ($urandom_range(0, 2) == 0);
      redirect.miss  = ($urandom_range(0, 1) == 0);
      redirect.fence = ($urandom_range(0, 1) == 0);
    end
    redirect.mtvec     = random_word_addr();
    redirect.mepc      = random_word_addr();
    redirect.miss_addr = random_word_addr();
    redirect.fence_npc = random_word_addr();
    btac_upd.valid     = ($urandom_range(0, 9) == 0);
    btac_upd.pc        = random_word_addr();
    btac_upd.target    = random_word_addr();
  endtask

  function automatic strobe_t random_strobe();
    return ($urandom_range(0, 3) == 0) ? strobe_t'($urandom) : 8'hff;
  endfunction

  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Run stopped after %0d cycles without reaching the end", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hc570_4a37));
    redirect   = '0;
    halt       = 1'b0;
    btac_upd   = '0;
    aw         = '0;
    awvalid    = 1'b0;
    w          = '0;
    wvalid     = 1'b0;
    bready     = 1'b1;
    @(posedge reset);
    repeat (load_writes) begin
      axi_write(random_word_addr(), {$urandom, $urandom}, random_strobe());
    end
    fork
      repeat (mix_cycles) drive_mix_cycle();
      repeat (mix_writes) begin
        repeat ($urandom_range(0, 12)) @(negedge clock);
        axi_write(random_word_addr(), {$urandom, $urandom}, random_strobe());
      end
    join
    @(negedge clock);
    redirect = '0;
    halt     = 1'b0;
    btac_upd = '0;
    bready   = 1'b1;
    repeat (drain_cycles) @(negedge clock);
    if (aw_count != b_count) begin
      tb_errors++;
      $display("Saw %0d AXI writes but %0d write responses", aw_count, b_count);
    end
    $display("Checks %0d, errors %0d", checks, errors + tb_errors);
    if (errors + tb_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- test/tb_clock.sv
module tb_clock (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock; // Period of 8
  end

  initial begin
    reset = 1'b0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
  end

endmodule
